// ==== src.f ====
+incdir+.
zb_addr_pkg.sv
zb_csr_pkg.sv
zb_chan_if.sv
zb_skid_buf.sv
zb_csr_regs.sv
zb_mem_profiler.sv
zb_host_window.sv
zb_dram_rebase.sv
zb_bridge_top.sv
zb_bridge_tb.sv

// ==== zb_addr_pkg.sv ====
`include "zb_consts.svh"

package zb_addr_pkg;

   typedef logic [`ZB_HOST_ADDR_W-1:0] host_addr_t;
   typedef logic [`ZB_ADDR_W-1:0]      core_addr_t;
   typedef logic [`ZB_ADDR_W-1:0]      dram_addr_t;
   typedef logic [`ZB_REGION_W-1:0]    region_idx_t;

   // request as seen through the host window
   typedef struct packed {
      host_addr_t             addr;
      logic                   we;
      logic [`ZB_DATA_W-1:0]  data;
   } host_req_s;

   // request in the core address space
   typedef struct packed {
      core_addr_t             addr;
      logic                   we;
      logic [`ZB_DATA_W-1:0]  data;
   } core_req_s;

   // request after rebasing into host DRAM
   typedef struct packed {
      dram_addr_t             addr;
      logic                   we;
      logic [`ZB_DATA_W-1:0]  data;
   } dram_req_s;

endpackage

// ==== zb_bridge_tb.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_bridge_tb
   import zb_addr_pkg::*, zb_csr_pkg::*;
();

   localparam int MAX_CYCLES = 4000;
   localparam int NUM_REQS   = 60;

   logic aclk = 1'b0;
   logic reset_i, csr_we_i, csr_re_i, csr_rvalid_o, sys_resetn_o;
   logic [`ZB_CSR_ADDR_W-1:0] csr_addr_i;
   csr_word_t csr_wdata_i, csr_rdata_o;
   logic host_valid_i, host_ready_o, host_we_i;
   host_addr_t host_addr_i;
   logic [`ZB_DATA_W-1:0] host_data_i, core_host_data_o, core_mem_data_i, dram_data_o;
   logic core_host_valid_o, core_host_we_o;
   logic core_host_ready_i = 1'b0;
   core_addr_t core_host_addr_o, core_mem_addr_i;
   logic core_mem_valid_i, core_mem_ready_o, core_mem_we_i;
   logic dram_valid_o, dram_we_o;
   logic dram_ready_i = 1'b0;
   dram_addr_t dram_addr_o;

   integer seed = 46241;
   int errors = 0;
   int cycles = 0;
   int mem_in = 0;
   int mem_out = 0;
   logic rand_ready = 1'b0;
   csr_word_t exp_base = '0;
   logic [`ZB_NUM_REGIONS-1:0] exp_map = '0;
   core_req_s host_q[$];
   core_req_s mem_q[$];

   zb_bridge_top zb_bridge_top_i (.*);

   always #20 aclk = ~aclk;

   // host bit 29 inverted into bit 31, bits 30..28 cleared
   function automatic core_req_s xlate_host(host_req_s h);
      core_req_s c;
      c.addr = {~h.addr[29], 3'b000, h.addr[27:0]};
      c.we   = h.we;
      c.data = h.data;
      return c;
   endfunction

   function automatic dram_req_s rebase_dram(core_req_s c, csr_word_t base);
      dram_req_s d;
      d.addr = (c.addr ^ 32'h8000_0000) + base;
      d.we   = c.we;
      d.data = c.data;
      return d;
   endfunction

   function automatic region_idx_t region_of(core_addr_t a);
      return a[29:23];
   endfunction

   task automatic write_csr(input logic [2:0] idx, input csr_word_t val);
      @(posedge aclk);
      csr_we_i    <= 1'b1;
      csr_addr_i  <= idx;
      csr_wdata_i <= val;
      @(posedge aclk);
      csr_we_i    <= 1'b0;
   endtask

   // read data is due exactly one cycle after the strobe
   task automatic check_csr(input logic [2:0] idx, input csr_word_t exp);
      @(posedge aclk);
      csr_re_i   <= 1'b1;
      csr_addr_i <= idx;
      @(posedge aclk);
      csr_re_i   <= 1'b0;
      @(posedge aclk);
      if (csr_rvalid_o !== 1'b1) begin
         $display("Error at %0t: no read valid one cycle after read of CSR %0d", $time, idx);
         errors++;
      end else if (csr_rdata_o !== exp) begin
         $display("Error at %0t: CSR %0d read %h, expected %h", $time, idx, csr_rdata_o, exp);
         errors++;
      end
   endtask

   task automatic send_host_reqs(input int n);
      for (int i = 0; i < n; i++) begin
         host_valid_i <= 1'b1;
         host_addr_i  <= $random(seed);
         host_we_i    <= $random(seed) & 1;
         host_data_i  <= $random(seed);
         do @(posedge aclk); while (host_ready_o !== 1'b1);
      end
      host_valid_i <= 1'b0;
   endtask

   task automatic send_mem_reqs(input int n);
      for (int i = 0; i < n; i++) begin
         core_mem_valid_i <= 1'b1;
         core_mem_addr_i  <= {1'b1, 31'($random(seed))};
         core_mem_we_i    <= $random(seed) & 1;
         core_mem_data_i  <= $random(seed);
         do @(posedge aclk); while (core_mem_ready_o !== 1'b1);
      end
      core_mem_valid_i <= 1'b0;
   endtask

   // random back-pressure on both outputs
   always @(posedge aclk) begin
      core_host_ready_i <= rand_ready && (($random(seed) & 1) == 1);
      dram_ready_i      <= rand_ready && (($random(seed) & 1) == 1);
   end

   // record expected items at each input handshake
   always @(posedge aclk) begin
      host_req_s h_in;
      core_req_s m_in;
      if (!reset_i && host_valid_i && host_ready_o) begin
         h_in.addr = host_addr_i;
         h_in.we   = host_we_i;
         h_in.data = host_data_i;
         host_q.push_back(xlate_host(h_in));
      end
      if (!reset_i && core_mem_valid_i && core_mem_ready_o) begin
         m_in.addr = core_mem_addr_i;
         m_in.we   = core_mem_we_i;
         m_in.data = core_mem_data_i;
         mem_q.push_back(m_in);
         mem_in++;
      end
   end

   // compare at each output handshake
   always @(posedge aclk) begin
      core_req_s exp_h;
      core_req_s req_m;
      dram_req_s exp_d;
      if (!reset_i && core_host_valid_o && core_host_ready_i) begin
         if (host_q.size() == 0) begin
            $display("Error at %0t: core host output with no request pending", $time);
            errors++;
         end else begin
            exp_h = host_q.pop_front();
            if ({core_host_addr_o, core_host_we_o, core_host_data_o} !== exp_h) begin
               $display("Error at %0t: core host got %h/%b/%h, expected %h/%b/%h", $time,
                        core_host_addr_o, core_host_we_o, core_host_data_o,
                        exp_h.addr, exp_h.we, exp_h.data);
               errors++;
            end
         end
      end
      if (!reset_i && dram_valid_o && dram_ready_i) begin
         mem_out++;
         if (mem_q.size() == 0) begin
            $display("Error at %0t: DRAM output with no request pending", $time);
            errors++;
         end else begin
            req_m = mem_q.pop_front();
            exp_d = rebase_dram(req_m, exp_base);
            exp_map[region_of(req_m.addr)] = 1'b1;
            if ({dram_addr_o, dram_we_o, dram_data_o} !== exp_d) begin
               $display("Error at %0t: DRAM got %h/%b/%h, expected %h/%b/%h", $time,
                        dram_addr_o, dram_we_o, dram_data_o, exp_d.addr, exp_d.we, exp_d.data);
               errors++;
            end
         end
      end
   end

   always @(posedge aclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      csr_word_t val;
      reset_i <= 1'b1;
      csr_we_i <= 1'b0;
      csr_re_i <= 1'b0;
      csr_addr_i <= '0;
      csr_wdata_i <= '0;
      host_valid_i <= 1'b0;
      host_addr_i <= '0;
      host_we_i <= 1'b0;
      host_data_i <= '0;
      core_mem_valid_i <= 1'b0;
      core_mem_addr_i <= '0;
      core_mem_we_i <= 1'b0;
      core_mem_data_i <= '0;
      repeat (4) @(posedge aclk);
      reset_i <= 1'b0;

      // state right after reset
      @(posedge aclk);
      if ({sys_resetn_o, csr_rvalid_o, host_ready_o, core_mem_ready_o, core_host_valid_o,
           dram_valid_o} !== 6'b0) begin
         $display("Error at %0t: resetn, read valid, readies or valids not low after reset",
                  $time);
         errors++;
      end
      check_csr(CSR_SYS_RESET, '0);

      // writable registers keep only their defined bits
      for (int k = 0; k < 3; k++) begin
         val = $random(seed);
         write_csr(k, val);
         check_csr(k, (k == CSR_DRAM_BASE) ? val : (val & 32'h1));
      end
      write_csr(CSR_PROF0, $random(seed));
      check_csr(CSR_PROF0, '0);
      check_csr(7, '0);

      write_csr(CSR_SYS_RESET, 32'h1);
      @(posedge aclk);
      if (sys_resetn_o !== 1'b1) begin
         $display("Error at %0t: sys_resetn_o not high after release", $time);
         errors++;
      end
      rand_ready <= 1'b1;
      send_host_reqs(NUM_REQS);
      // last request is queued at the edge that accepted it
      @(posedge aclk);
      while (host_q.size() != 0) @(posedge aclk);

      exp_base = $random(seed);
      write_csr(CSR_DRAM_BASE, exp_base);
      send_mem_reqs(NUM_REQS);
      @(posedge aclk);
      while (mem_q.size() != 0) @(posedge aclk);
      if (mem_in != mem_out) begin
         $display("Error at %0t: %0d DRAM items in, %0d out", $time, mem_in, mem_out);
         errors++;
      end

      for (int k = 0; k < 4; k++) begin
         check_csr(CSR_PROF0 + k, exp_map[k*32 +: 32]);
      end
      write_csr(CSR_SYS_RESET, 32'h0);
      write_csr(CSR_SYS_RESET, 32'h1);
      for (int k = 0; k < 4; k++) begin
         check_csr(CSR_PROF0 + k, '0);
      end

      $display("Run done: %0d errors, %0d DRAM items in, %0d out", errors, mem_in, mem_out);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== zb_bridge_top.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_bridge_top
   import zb_addr_pkg::*, zb_csr_pkg::*;
(
   input  logic                       aclk,
   input  logic                       reset_i,
   // host register port
   input  logic                       csr_we_i,
   input  logic                       csr_re_i,
   input  logic [`ZB_CSR_ADDR_W-1:0]  csr_addr_i,
   input  csr_word_t                  csr_wdata_i,
   output csr_word_t                  csr_rdata_o,
   output logic                       csr_rvalid_o,
   output logic                       sys_resetn_o,
   // host requests into the core
   input  logic                       host_valid_i,
   output logic                       host_ready_o,
   input  host_addr_t                 host_addr_i,
   input  logic                       host_we_i,
   input  logic [`ZB_DATA_W-1:0]      host_data_i,
   output logic                       core_host_valid_o,
   input  logic                       core_host_ready_i,
   output core_addr_t                 core_host_addr_o,
   output logic                       core_host_we_o,
   output logic [`ZB_DATA_W-1:0]      core_host_data_o,
   // core memory requests out to DRAM
   input  logic                       core_mem_valid_i,
   output logic                       core_mem_ready_o,
   input  core_addr_t                 core_mem_addr_i,
   input  logic                       core_mem_we_i,
   input  logic [`ZB_DATA_W-1:0]      core_mem_data_i,
   output logic                       dram_valid_o,
   input  logic                       dram_ready_i,
   output dram_addr_t                 dram_addr_o,
   output logic                       dram_we_o,
   output logic [`ZB_DATA_W-1:0]      dram_data_o
);

   logic                       core_reset;
   csr_word_t                  dram_base;
   logic [`ZB_NUM_REGIONS-1:0] region_map;
   logic                       touch_v;
   core_addr_t                 touch_addr;
   host_req_s                  host_req;

   zb_chan_if #(.payload_t(core_req_s)) core_host_ch ();
   zb_chan_if #(.payload_t(core_req_s)) core_mem_ch ();
   zb_chan_if #(.payload_t(dram_req_s)) dram_ch ();

   assign host_req = '{addr: host_addr_i, we: host_we_i, data: host_data_i};

   assign core_host_valid_o  = core_host_ch.valid;
   assign core_host_ch.ready = core_host_ready_i;
   assign core_host_addr_o   = core_host_ch.payload.addr;
   assign core_host_we_o     = core_host_ch.payload.we;
   assign core_host_data_o   = core_host_ch.payload.data;

   assign core_mem_ch.valid   = core_mem_valid_i;
   assign core_mem_ch.payload = '{addr: core_mem_addr_i, we: core_mem_we_i,
                                  data: core_mem_data_i};
   assign core_mem_ready_o    = core_mem_ch.ready;

   assign dram_valid_o  = dram_ch.valid;
   assign dram_ch.ready = dram_ready_i;
   assign dram_addr_o   = dram_ch.payload.addr;
   assign dram_we_o     = dram_ch.payload.we;
   assign dram_data_o   = dram_ch.payload.data;

   zb_csr_regs csr_regs_i (
      .aclk         (aclk),
      .reset_i      (reset_i),
      .csr_we_i     (csr_we_i),
      .csr_re_i     (csr_re_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .region_map_i (region_map),
      .sys_resetn_o (sys_resetn_o),
      .core_reset_o (core_reset),
      .dram_base_o  (dram_base)
   );

   zb_host_window host_window_i (
      .aclk         (aclk),
      .reset_i      (reset_i),
      .core_reset_i (core_reset),
      .host_valid_i (host_valid_i),
      .host_ready_o (host_ready_o),
      .host_req_i   (host_req),
      .core_ch      (core_host_ch)
   );

   zb_dram_rebase dram_rebase_i (
      .aclk         (aclk),
      .reset_i      (reset_i),
      .core_reset_i (core_reset),
      .dram_base_i  (dram_base),
      .core_ch      (core_mem_ch),
      .dram_ch      (dram_ch),
      .touch_v_o    (touch_v),
      .touch_addr_o (touch_addr)
   );

   zb_mem_profiler mem_profiler_i (
      .aclk         (aclk),
      .reset_i      (reset_i),
      .core_reset_i (core_reset),
      .touch_v_i    (touch_v),
      .touch_addr_i (touch_addr),
      .region_map_o (region_map)
   );

endmodule

// ==== zb_chan_if.sv ====
`timescale 1ns/1ns

interface zb_chan_if #(
   parameter type payload_t = logic
) ();

   logic     valid;
   logic     ready;
   payload_t payload;

   // producer side
   modport src (
      output valid,
      output payload,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  payload,
      output ready
   );

endinterface

// ==== zb_consts.svh ====
`ifndef ZB_CONSTS_SVH
`define ZB_CONSTS_SVH

// data path and register width
`define ZB_DATA_W 32

// host window and core address widths
`define ZB_HOST_ADDR_W 30
`define ZB_ADDR_W 32

// core view of the start of DRAM
`define ZB_CORE_DRAM_BASE 32'h8000_0000

// host bit 29 picks DRAM window or local window
`define ZB_HOST_SEL_BIT 29
`define ZB_KEEP_BITS 28

// profiler region field, core address bits 29 down to 23
`define ZB_REGION_MSB 29
`define ZB_REGION_W 7
`define ZB_NUM_REGIONS 128

`define ZB_CSR_ADDR_W 3
`define ZB_NUM_CSR 7

`endif

// ==== zb_csr_pkg.sv ====
`include "zb_consts.svh"

package zb_csr_pkg;

   typedef logic [`ZB_DATA_W-1:0] csr_word_t;

   // register map
   typedef enum logic [`ZB_CSR_ADDR_W-1:0] {
      // bit 0 set lets the system run
      CSR_SYS_RESET  = 3'd0,
      // host has allocated DRAM for the core
      CSR_DRAM_VALID = 3'd1,
      CSR_DRAM_BASE  = 3'd2,
      // read-only profiler words, PROF0 holds regions 31 down to 0
      CSR_PROF0      = 3'd3,
      CSR_PROF1      = 3'd4,
      CSR_PROF2      = 3'd5,
      CSR_PROF3      = 3'd6
   } csr_idx_e;

endpackage

// ==== zb_csr_regs.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_csr_regs
   import zb_csr_pkg::*;
(
   input  logic                       aclk,
   input  logic                       reset_i,
   input  logic                       csr_we_i,
   input  logic                       csr_re_i,
   input  logic [`ZB_CSR_ADDR_W-1:0]  csr_addr_i,
   input  csr_word_t                  csr_wdata_i,
   output csr_word_t                  csr_rdata_o,
   output logic                       csr_rvalid_o,
   input  logic [`ZB_NUM_REGIONS-1:0] region_map_i,
   output logic                       sys_resetn_o,
   output logic                       core_reset_o,
   output csr_word_t                  dram_base_o
);

   logic      sys_run_r;
   logic      dram_valid_r;
   csr_word_t dram_base_r;
   csr_word_t rd_bank [`ZB_NUM_CSR];

   // only bit 0 of the flag registers is stored
   always_ff @(posedge aclk) begin
      if (reset_i) begin
         sys_run_r    <= 1'b0;
         dram_valid_r <= 1'b0;
         dram_base_r  <= '0;
      end else if (csr_we_i) begin
         case (csr_idx_e'(csr_addr_i))
            CSR_SYS_RESET:  sys_run_r    <= csr_wdata_i[0];
            CSR_DRAM_VALID: dram_valid_r <= csr_wdata_i[0];
            CSR_DRAM_BASE:  dram_base_r  <= csr_wdata_i;
            default:        ;
         endcase
      end
   end

   // readback view of every mapped index
   always_comb begin
      rd_bank[CSR_SYS_RESET]  = {{(`ZB_DATA_W-1){1'b0}}, sys_run_r};
      rd_bank[CSR_DRAM_VALID] = {{(`ZB_DATA_W-1){1'b0}}, dram_valid_r};
      rd_bank[CSR_DRAM_BASE]  = dram_base_r;
      for (int k = 0; k < `ZB_NUM_REGIONS / `ZB_DATA_W; k++) begin
         rd_bank[CSR_PROF0 + k] = region_map_i[k*`ZB_DATA_W +: `ZB_DATA_W];
      end
   end

   always_ff @(posedge aclk) begin
      if (reset_i) begin
         csr_rvalid_o <= 1'b0;
      end else begin
         csr_rvalid_o <= csr_re_i;
      end
   end

   // unmapped indices read as zero
   always_ff @(posedge aclk) begin
      if (csr_re_i) begin
         csr_rdata_o <= (csr_addr_i < `ZB_NUM_CSR) ? rd_bank[csr_addr_i] : '0;
      end
   end

   assign sys_resetn_o = sys_run_r;
   assign dram_base_o  = dram_base_r;

   // core held in reset until the host lets it run
   assign core_reset_o = ~sys_run_r | reset_i;

   // host drives one strobe at a time
   a_one_strobe: assert property (@(posedge aclk) disable iff (reset_i)
      !(csr_we_i && csr_re_i));

endmodule

// ==== zb_dram_rebase.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_dram_rebase
   import zb_addr_pkg::*, zb_csr_pkg::*;
(
   input  logic       aclk,
   input  logic       reset_i,
   input  logic       core_reset_i,
   input  csr_word_t  dram_base_i,
   zb_chan_if.snk     core_ch,
   zb_chan_if.src     dram_ch,
   output logic       touch_v_o,
   output core_addr_t touch_addr_o
);

   dram_req_s dram_req;

   zb_chan_if #(.payload_t(core_req_s)) buf_ch ();

   zb_skid_buf #(.payload_t(core_req_s)) skid_i (
      .aclk    (aclk),
      .reset_i (reset_i),
      .flush_i (core_reset_i),
      .in_ch   (core_ch),
      .out_ch  (buf_ch)
   );

   // strip the core DRAM base, then move into the block the host allocated
   always_comb begin
      dram_req.addr = (buf_ch.payload.addr ^ `ZB_CORE_DRAM_BASE) + dram_base_i;
      dram_req.we   = buf_ch.payload.we;
      dram_req.data = buf_ch.payload.data;
   end

   assign dram_ch.valid   = buf_ch.valid;
   assign dram_ch.payload = dram_req;
   assign buf_ch.ready    = dram_ch.ready;

   // profiler sees the core address of every accepted request
   assign touch_v_o    = buf_ch.valid & dram_ch.ready;
   assign touch_addr_o = buf_ch.payload.addr;

endmodule

// ==== zb_host_window.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_host_window
   import zb_addr_pkg::*;
(
   input  logic      aclk,
   input  logic      reset_i,
   input  logic      core_reset_i,
   input  logic      host_valid_i,
   output logic      host_ready_o,
   input  host_req_s host_req_i,
   zb_chan_if.src    core_ch
);

   core_req_s core_req;

   zb_chan_if #(.payload_t(core_req_s)) xlate_ch ();

   // host 0x0xxx_xxxx lands in core DRAM at 0x8xxx_xxxx,
   // host 0x2xxx_xxxx lands in core local space at 0x0xxx_xxxx
   always_comb begin
      core_req.addr = {~host_req_i.addr[`ZB_HOST_SEL_BIT],
                       {(`ZB_ADDR_W - `ZB_KEEP_BITS - 1){1'b0}},
                       host_req_i.addr[`ZB_KEEP_BITS-1:0]};
      core_req.we   = host_req_i.we;
      core_req.data = host_req_i.data;
   end

   assign xlate_ch.valid   = host_valid_i;
   assign xlate_ch.payload = core_req;
   assign host_ready_o     = xlate_ch.ready;

   zb_skid_buf #(.payload_t(core_req_s)) skid_i (
      .aclk    (aclk),
      .reset_i (reset_i),
      .flush_i (core_reset_i),
      .in_ch   (xlate_ch),
      .out_ch  (core_ch)
   );

endmodule

// ==== zb_mem_profiler.sv ====
`timescale 1ns/1ns

`include "zb_consts.svh"

module zb_mem_profiler
   import zb_addr_pkg::*;
(
   input  logic                       aclk,
   input  logic                       reset_i,
   input  logic                       core_reset_i,
   input  logic                       touch_v_i,
   input  core_addr_t                 touch_addr_i,
   output logic [`ZB_NUM_REGIONS-1:0] region_map_o
);

   region_idx_t                 region;
   logic [`ZB_NUM_REGIONS-1:0]  map_r;

   // each region covers 8 MB of core address space
   assign region = touch_addr_i[`ZB_REGION_MSB -: `ZB_REGION_W];

   // bits stay set until the core is reset again
   always_ff @(posedge aclk) begin
      if (reset_i || core_reset_i) begin
         map_r <= '0;
      end else if (touch_v_i) begin
         map_r[region] <= 1'b1;
      end
   end

   assign region_map_o = map_r;

endmodule

// ==== zb_skid_buf.sv ====
`timescale 1ns/1ns

module zb_skid_buf #(
   parameter type payload_t = logic
) (
   input  logic   aclk,
   input  logic   reset_i,
   input  logic   flush_i,
   zb_chan_if.snk in_ch,
   zb_chan_if.src out_ch
);

   logic     out_valid_r;
   logic     skid_valid_r;
   payload_t out_data_r;
   payload_t skid_data_r;
   logic     in_fire;
   logic     out_free;

   // ready comes from a flop, so the sink's ready never reaches the source
   assign in_ch.ready = ~skid_valid_r & ~flush_i;
   assign in_fire     = in_ch.valid & in_ch.ready;

   // output slot is empty or drains at this edge
   assign out_free = ~out_valid_r | out_ch.ready;

   always_ff @(posedge aclk) begin
      if (reset_i || flush_i) begin
         out_valid_r  <= 1'b0;
         skid_valid_r <= 1'b0;
      end else if (out_free) begin
         out_valid_r  <= skid_valid_r | in_fire;
         skid_valid_r <= 1'b0;
      end else if (in_fire) begin
         skid_valid_r <= 1'b1;
      end
   end

   // the older skid item always goes out first
   always_ff @(posedge aclk) begin
      if (out_free && (skid_valid_r || in_fire)) begin
         out_data_r <= skid_valid_r ? skid_data_r : in_ch.payload;
      end
      if (!out_free && in_fire) begin
         skid_data_r <= in_ch.payload;
      end
   end

   assign out_ch.valid   = out_valid_r;
   assign out_ch.payload = out_data_r;

   // a stalled item stays put until the sink takes it
   a_out_hold: assert property (@(posedge aclk) disable iff (reset_i || flush_i)
      out_ch.valid && !out_ch.ready |=> out_ch.valid && $stable(out_ch.payload));

endmodule
